// File: design/soc_pkg.sv
package soc_pkg;

  // APB bus widths
  localparam int ADDR_W = 12;
  localparam int DATA_W = 16;

  // Region field is paddr[11:8], register index is paddr[3:2]
  localparam int REGION_LSB = 8;
  localparam int REG_LSB = 2;

  typedef enum logic [3:0] {
    PER_UART = 4'd0,
    PER_ENC  = 4'd1,
    PER_HEX  = 4'd2,
    PER_SW   = 4'd3,
    PER_NONE = 4'd15
  } periph_e;

  // UART registers
  localparam logic [1:0] REG_UART_DATA = 2'd0;
  localparam logic [1:0] REG_UART_STAT = 2'd1;

  // Encoder registers
  localparam logic [1:0] REG_ENC_COUNT = 2'd0;
  localparam logic [1:0] REG_ENC_STAT = 2'd1;
  localparam logic [1:0] REG_ENC_RGB = 2'd2;

  // Display register
  localparam logic [1:0] REG_HEX_VALUE = 2'd0;

  // Request fields broadcast to every peripheral
  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              pwrite;
    logic [DATA_W-1:0] pwdata;
    logic              penable;
  } apb_req_t;

  // Encoder count runs 0..23
  localparam int ENC_STEPS = 24;
  localparam int ENC_CNT_W = 5;
  localparam logic [ENC_CNT_W-1:0] ENC_MAX = ENC_CNT_W'(ENC_STEPS - 1);
  localparam logic [DATA_W-1:0] ENC_MOD = DATA_W'(ENC_STEPS);

  // Clock cycles per serial bit
  localparam int UART_DIV = 16;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_e;

  // Segments g..a, active low
  typedef logic [6:0] seg7_t;

endpackage

// File: design/periph_decode.sv
`timescale 1ns/100ps

module periph_decode (
  input  logic                        clock_50,
  input  logic                        rst,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [soc_pkg::ADDR_W-1:0]  paddr,
  input  logic [soc_pkg::DATA_W-1:0]  pwdata,
  input  logic [7:0]                  sw,
  output soc_pkg::apb_req_t           req,
  output logic                        sel_uart,
  output logic                        sel_enc,
  output logic                        sel_hex,
  input  logic [soc_pkg::DATA_W-1:0]  rdata_uart,
  input  logic [soc_pkg::DATA_W-1:0]  rdata_enc,
  input  logic [soc_pkg::DATA_W-1:0]  rdata_hex,
  output logic [soc_pkg::DATA_W-1:0]  prdata,
  output logic                        pslverr
);

  soc_pkg::periph_e region;

  assign req = '{paddr: paddr, pwrite: pwrite, pwdata: pwdata, penable: penable};

  always_comb begin
    case (paddr[soc_pkg::REGION_LSB +: 4])
      4'd0: region = soc_pkg::PER_UART;
      4'd1: region = soc_pkg::PER_ENC;
      4'd2: region = soc_pkg::PER_HEX;
      4'd3: region = soc_pkg::PER_SW;
      default: region = soc_pkg::PER_NONE;
    endcase
  end

  assign sel_uart = psel && (region == soc_pkg::PER_UART);
  assign sel_enc = psel && (region == soc_pkg::PER_ENC);
  assign sel_hex = psel && (region == soc_pkg::PER_HEX);

  // Read data mux, zero when idle or unmapped
  always_comb begin
    prdata = '0;
    if (psel) begin
      case (region)
        soc_pkg::PER_UART: prdata = rdata_uart;
        soc_pkg::PER_ENC:  prdata = rdata_enc;
        soc_pkg::PER_HEX:  prdata = rdata_hex;
        soc_pkg::PER_SW:   prdata = {8'h00, sw};
        default:           prdata = '0;
      endcase
    end
  end

  assign pslverr = psel && penable && (region == soc_pkg::PER_NONE);

  // Master must hold psel through the access phase
  a_penable_needs_psel: assert property (
    @(posedge clock_50) disable iff (rst) penable |-> psel
  ) else $error("penable high without psel");

  // Access phase only directly after a setup phase
  a_access_after_setup: assert property (
    @(posedge clock_50) disable iff (rst) penable |-> $past(psel && !penable)
  ) else $error("penable high without preceding setup cycle");

endmodule

// File: design/uart.sv
`timescale 1ns/100ps

module uart #(
  parameter int div = soc_pkg::UART_DIV
) (
  input  logic                        clock_50,
  input  logic                        rst,
  input  soc_pkg::apb_req_t           req,
  input  logic                        sel,
  output logic [soc_pkg::DATA_W-1:0]  prdata,
  output logic                        tx,
  input  logic                        rx
);

  soc_pkg::uart_state_e tx_state;
  soc_pkg::uart_state_e rx_state;
  logic [$clog2(div)-1:0] tx_cnt;
  logic [$clog2(div)-1:0] rx_cnt;
  logic [2:0] tx_bit;
  logic [2:0] rx_bit;
  logic [7:0] tx_shift;
  logic [7:0] rx_shift;
  logic [7:0] rx_data;
  logic [1:0] rx_sync;
  logic       rx_valid;
  logic       tx_busy;
  logic [1:0] reg_idx;
  logic       wr_data;
  logic       rd_data;

  assign reg_idx = req.paddr[soc_pkg::REG_LSB +: 2];
  assign wr_data = sel && req.penable && req.pwrite && (reg_idx == soc_pkg::REG_UART_DATA);
  assign rd_data = sel && req.penable && !req.pwrite && (reg_idx == soc_pkg::REG_UART_DATA);
  assign tx_busy = (tx_state != soc_pkg::IDLE);

  // Transmitter, LSB first
  always_ff @(posedge clock_50) begin
    if (rst) begin
      tx_state <= soc_pkg::IDLE;
      tx_cnt <= '0;
      tx_bit <= '0;
      tx <= 1'b1;
    end else begin
      case (tx_state)
        soc_pkg::IDLE: begin
          tx <= 1'b1;
          if (wr_data) begin
            tx_state <= soc_pkg::START;
            tx <= 1'b0;
            tx_cnt <= '0;
          end
        end
        soc_pkg::START: begin
          if (tx_cnt == div - 1) begin
            tx_cnt <= '0;
            tx_bit <= '0;
            tx <= tx_shift[0];
            tx_state <= soc_pkg::DATA;
          end else begin
            tx_cnt <= tx_cnt + 1'b1;
          end
        end
        soc_pkg::DATA: begin
          if (tx_cnt == div - 1) begin
            tx_cnt <= '0;
            if (tx_bit == 3'd7) begin
              tx <= 1'b1;
              tx_state <= soc_pkg::STOP;
            end else begin
              tx <= tx_shift[0];
              tx_bit <= tx_bit + 1'b1;
            end
          end else begin
            tx_cnt <= tx_cnt + 1'b1;
          end
        end
        default: begin
          if (tx_cnt == div - 1) begin
            tx_cnt <= '0;
            tx_state <= soc_pkg::IDLE;
          end else begin
            tx_cnt <= tx_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Shift register follows the bit boundaries above
  always_ff @(posedge clock_50) begin
    if (tx_state == soc_pkg::IDLE && wr_data) begin
      tx_shift <= req.pwdata[7:0];
    end else if (tx_state != soc_pkg::IDLE && tx_cnt == div - 1) begin
      tx_shift <= {1'b0, tx_shift[7:1]};
    end
  end

  // Receiver samples in the middle of each bit
  always_ff @(posedge clock_50) begin
    if (rst) begin
      rx_sync <= 2'b11;
      rx_state <= soc_pkg::IDLE;
      rx_cnt <= '0;
      rx_bit <= '0;
      rx_valid <= 1'b0;
      rx_data <= '0;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      if (rd_data) begin
        rx_valid <= 1'b0;
      end
      case (rx_state)
        soc_pkg::IDLE: begin
          rx_cnt <= '0;
          if (!rx_sync[1]) begin
            rx_state <= soc_pkg::START;
          end
        end
        soc_pkg::START: begin
          if (rx_cnt == div / 2 - 1) begin
            rx_cnt <= '0;
            rx_bit <= '0;
            // Line back high means a glitch, not a start bit
            rx_state <= rx_sync[1] ? soc_pkg::IDLE : soc_pkg::DATA;
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
        soc_pkg::DATA: begin
          if (rx_cnt == div - 1) begin
            rx_cnt <= '0;
            rx_shift <= {rx_sync[1], rx_shift[7:1]};
            rx_bit <= rx_bit + 1'b1;
            if (rx_bit == 3'd7) begin
              rx_state <= soc_pkg::STOP;
            end
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
        default: begin
          if (rx_cnt == div - 1) begin
            rx_cnt <= '0;
            rx_state <= soc_pkg::IDLE;
            if (rx_sync[1]) begin
              rx_data <= rx_shift;
              rx_valid <= 1'b1;
            end
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_comb begin
    case (reg_idx)
      soc_pkg::REG_UART_DATA: prdata = {8'h00, rx_data};
      soc_pkg::REG_UART_STAT: prdata = {14'h0000, rx_valid, tx_busy};
      default: prdata = '0;
    endcase
  end

  a_tx_idle_high: assert property (
    @(posedge clock_50) disable iff (rst) (tx_state == soc_pkg::IDLE) |-> tx
  ) else $error("tx low while transmitter is %s", tx_state.name());

endmodule

// File: design/quad_encoder.sv
`timescale 1ns/100ps

module quad_encoder (
  input  logic                        clock_50,
  input  logic                        rst,
  input  soc_pkg::apb_req_t           req,
  input  logic                        sel,
  output logic [soc_pkg::DATA_W-1:0]  prdata,
  input  logic [1:0]                  quad,
  input  logic                        button,
  output logic [2:0]                  rgb
);

  logic [1:0] quad_s1;
  logic [1:0] quad_s2;
  logic [1:0] quad_prev;
  logic       btn_s1;
  logic       btn_s2;
  logic       btn_prev;
  logic       btn_latch;
  logic [1:0] pos_new;
  logic [1:0] pos_old;
  logic [1:0] step;
  logic [soc_pkg::ENC_CNT_W-1:0] count;
  logic [soc_pkg::DATA_W-1:0] load_val;
  logic [1:0] reg_idx;
  logic       wr;

  assign reg_idx = req.paddr[soc_pkg::REG_LSB +: 2];
  assign wr = sel && req.penable && req.pwrite;
  assign load_val = req.pwdata % soc_pkg::ENC_MOD;

  // Gray code to position: 00->0, 01->1, 11->2, 10->3
  assign pos_new = {quad_s2[1], quad_s2[1] ^ quad_s2[0]};
  assign pos_old = {quad_prev[1], quad_prev[1] ^ quad_prev[0]};
  assign step = pos_new - pos_old;

  always_ff @(posedge clock_50) begin
    if (rst) begin
      quad_s1 <= 2'b00;
      quad_s2 <= 2'b00;
      quad_prev <= 2'b00;
      btn_s1 <= 1'b0;
      btn_s2 <= 1'b0;
      btn_prev <= 1'b0;
      btn_latch <= 1'b0;
      count <= '0;
      rgb <= 3'b000;
    end else begin
      quad_s1 <= quad;
      quad_s2 <= quad_s1;
      quad_prev <= quad_s2;
      btn_s1 <= button;
      btn_s2 <= btn_s1;
      btn_prev <= btn_s2;

      // Step of 2 is a double jump and is ignored
      if (wr && reg_idx == soc_pkg::REG_ENC_COUNT) begin
        count <= load_val[soc_pkg::ENC_CNT_W-1:0];
      end else if (step == 2'd1) begin
        count <= (count == soc_pkg::ENC_MAX) ? '0 : count + 1'b1;
      end else if (step == 2'd3) begin
        count <= (count == '0) ? soc_pkg::ENC_MAX : count - 1'b1;
      end

      if (wr && reg_idx == soc_pkg::REG_ENC_STAT) begin
        btn_latch <= 1'b0;
      end
      if (btn_s2 && !btn_prev) begin
        btn_latch <= 1'b1;
      end

      if (wr && reg_idx == soc_pkg::REG_ENC_RGB) begin
        rgb <= req.pwdata[2:0];
      end
    end
  end

  always_comb begin
    case (reg_idx)
      soc_pkg::REG_ENC_COUNT: prdata = {11'h000, count};
      soc_pkg::REG_ENC_STAT:  prdata = {15'h0000, btn_latch};
      soc_pkg::REG_ENC_RGB:   prdata = {13'h0000, rgb};
      default: prdata = '0;
    endcase
  end

  a_count_in_range: assert property (
    @(posedge clock_50) disable iff (rst) count < soc_pkg::ENC_STEPS
  ) else $error("encoder count %0d out of range", count);

endmodule

// File: design/hex_display.sv
`timescale 1ns/100ps

module hex_display (
  input  logic                        clock_50,
  input  logic                        rst,
  input  soc_pkg::apb_req_t           req,
  input  logic                        sel,
  output logic [soc_pkg::DATA_W-1:0]  prdata,
  output soc_pkg::seg7_t              hex0,
  output soc_pkg::seg7_t              hex1,
  output soc_pkg::seg7_t              hex2,
  output soc_pkg::seg7_t              hex3
);

  logic [soc_pkg::DATA_W-1:0] value;
  logic wr;

  function automatic soc_pkg::seg7_t font(input logic [3:0] nib);
    case (nib)
      4'h0: font = 7'h40;
      4'h1: font = 7'h79;
      4'h2: font = 7'h24;
      4'h3: font = 7'h30;
      4'h4: font = 7'h19;
      4'h5: font = 7'h12;
      4'h6: font = 7'h02;
      4'h7: font = 7'h78;
      4'h8: font = 7'h00;
      4'h9: font = 7'h10;
      4'hA: font = 7'h08;
      4'hB: font = 7'h03;
      4'hC: font = 7'h46;
      4'hD: font = 7'h21;
      4'hE: font = 7'h06;
      default: font = 7'h0E;
    endcase
  endfunction

  assign wr = sel && req.penable && req.pwrite &&
              (req.paddr[soc_pkg::REG_LSB +: 2] == soc_pkg::REG_HEX_VALUE);

  always_ff @(posedge clock_50) begin
    if (rst) begin
      value <= '0;
    end else if (wr) begin
      value <= req.pwdata;
    end
  end

  // Segment registers lag the value by one clock
  always_ff @(posedge clock_50) begin
    if (rst) begin
      hex0 <= font(4'h0);
      hex1 <= font(4'h0);
      hex2 <= font(4'h0);
      hex3 <= font(4'h0);
    end else begin
      hex0 <= font(value[3:0]);
      hex1 <= font(value[7:4]);
      hex2 <= font(value[11:8]);
      hex3 <= font(value[15:12]);
    end
  end

  assign prdata = (req.paddr[soc_pkg::REG_LSB +: 2] == soc_pkg::REG_HEX_VALUE) ? value : '0;

endmodule

// File: design/soc_periph.sv
`timescale 1ns/100ps

module soc_periph (
  input  logic                        clock_50,
  input  logic                        rst,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [soc_pkg::ADDR_W-1:0]  paddr,
  input  logic [soc_pkg::DATA_W-1:0]  pwdata,
  output logic [soc_pkg::DATA_W-1:0]  prdata,
  output logic                        pslverr,
  input  logic [7:0]                  sw,
  input  logic [1:0]                  quad,
  input  logic                        button,
  output logic [2:0]                  rgb,
  output logic                        serial_tx,
  input  logic                        serial_rx,
  output soc_pkg::seg7_t              hex0,
  output soc_pkg::seg7_t              hex1,
  output soc_pkg::seg7_t              hex2,
  output soc_pkg::seg7_t              hex3
);

  soc_pkg::apb_req_t req;
  logic sel_uart;
  logic sel_enc;
  logic sel_hex;
  logic [soc_pkg::DATA_W-1:0] rdata_uart;
  logic [soc_pkg::DATA_W-1:0] rdata_enc;
  logic [soc_pkg::DATA_W-1:0] rdata_hex;

  periph_decode u_decode (
    .clock_50(clock_50), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .sw(sw), .req(req),
    .sel_uart(sel_uart), .sel_enc(sel_enc), .sel_hex(sel_hex),
    .rdata_uart(rdata_uart), .rdata_enc(rdata_enc), .rdata_hex(rdata_hex),
    .prdata(prdata), .pslverr(pslverr)
  );

  uart #(.div(soc_pkg::UART_DIV)) u_uart (
    .clock_50(clock_50), .rst(rst), .req(req), .sel(sel_uart),
    .prdata(rdata_uart), .tx(serial_tx), .rx(serial_rx)
  );

  quad_encoder u_enc (
    .clock_50(clock_50), .rst(rst), .req(req), .sel(sel_enc),
    .prdata(rdata_enc), .quad(quad), .button(button), .rgb(rgb)
  );

  hex_display u_hex (
    .clock_50(clock_50), .rst(rst), .req(req), .sel(sel_hex), .prdata(rdata_hex),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3)
  );

endmodule

// File: sim/soc_checker.sv
`timescale 1ns/100ps

module soc_checker (
  input logic                        clock_50,
  input logic                        rst,
  input logic                        psel,
  input logic                        penable,
  input logic                        pwrite,
  input logic [soc_pkg::ADDR_W-1:0]  paddr,
  input logic [soc_pkg::DATA_W-1:0]  pwdata,
  input logic [soc_pkg::DATA_W-1:0]  prdata,
  input logic                        pslverr,
  input logic [7:0]                  sw,
  input logic [1:0]                  quad,
  input logic                        button,
  input logic [2:0]                  rgb,
  input soc_pkg::seg7_t              hex0,
  input soc_pkg::seg7_t              hex1,
  input soc_pkg::seg7_t              hex2,
  input soc_pkg::seg7_t              hex3
);

  int errors = 0;
  int reads = 0;

  // Reference state
  logic [15:0] hex_val;
  logic [15:0] seg_val;
  logic [7:0]  uart_byte;
  logic        rx_pending;
  int          tx_left;
  int          enc_count;
  logic        btn_latch;
  logic [2:0]  rgb_val;
  logic [1:0]  quad_prev;
  logic        btn_prev;

  logic [3:0]  region;
  logic [1:0]  idx;
  logic        unmapped;
  logic [15:0] exp_data;
  logic [15:0] exp_mask;

  assign region = paddr[11:8];
  assign idx = paddr[3:2];
  assign unmapped = (region > 4'd3);

  function automatic soc_pkg::seg7_t seg_font(input logic [3:0] nib);
    soc_pkg::seg7_t table_g2a [16];
    table_g2a = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
    return table_g2a[nib];
  endfunction

  // Forward order 00, 01, 11, 10
  function automatic int step_dir(input logic [1:0] prev, input logic [1:0] curr);
    case ({prev, curr})
      4'b0001, 4'b0111, 4'b1110, 4'b1000: step_dir = 1;
      4'b0100, 4'b1101, 4'b1011, 4'b0010: step_dir = -1;
      default: step_dir = 0;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
    $display("ERR %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
    errors++;
  endtask

  always @(posedge clock_50) begin
    if (rst) begin
      hex_val <= '0;
      seg_val <= '0;
      uart_byte <= '0;
      rx_pending <= 1'b0;
      tx_left <= 0;
      enc_count <= 0;
      btn_latch <= 1'b0;
      rgb_val <= '0;
      quad_prev <= quad;
      btn_prev <= button;
    end else begin
      // Segments follow the value one clock later
      seg_val <= hex_val;
      quad_prev <= quad;
      btn_prev <= button;
      // One frame of busy time per accepted byte
      if (tx_left != 0) begin
        tx_left <= tx_left - 1;
      end
      if (quad != quad_prev) begin
        enc_count <= (enc_count + soc_pkg::ENC_STEPS + step_dir(quad_prev, quad))
                     % soc_pkg::ENC_STEPS;
      end
      if (button && !btn_prev) begin
        btn_latch <= 1'b1;
      end
      if (psel && penable) begin
        case (region)
          4'd0: begin
            if (idx == soc_pkg::REG_UART_DATA) begin
              if (pwrite) begin
                if (tx_left == 0) begin
                  tx_left <= 10 * soc_pkg::UART_DIV;
                  uart_byte <= pwdata[7:0];
                  rx_pending <= 1'b1;
                end
              end else begin
                rx_pending <= 1'b0;
              end
            end
          end
          4'd1: begin
            if (pwrite && idx == soc_pkg::REG_ENC_COUNT) begin
              enc_count <= int'(pwdata % soc_pkg::ENC_STEPS);
            end
            if (pwrite && idx == soc_pkg::REG_ENC_STAT) begin
              btn_latch <= 1'b0;
            end
            if (pwrite && idx == soc_pkg::REG_ENC_RGB) begin
              rgb_val <= pwdata[2:0];
            end
          end
          4'd2: begin
            if (pwrite && idx == soc_pkg::REG_HEX_VALUE) begin
              hex_val <= pwdata;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Expected read data
  always_comb begin
    exp_data = '0;
    exp_mask = 16'hFFFF;
    case (region)
      4'd0: begin
        if (idx == soc_pkg::REG_UART_DATA) begin
          exp_data = {8'h00, uart_byte};
        end else if (idx == soc_pkg::REG_UART_STAT) begin
          exp_data = {15'h0000, tx_left != 0};
          // rx_valid rises at a line-dependent time while a byte is in flight
          exp_mask = rx_pending ? 16'hFFFD : 16'hFFFF;
        end
      end
      4'd1: begin
        if (idx == soc_pkg::REG_ENC_COUNT) begin
          exp_data = 16'(enc_count);
        end else if (idx == soc_pkg::REG_ENC_STAT) begin
          exp_data = {15'h0000, btn_latch};
        end else if (idx == soc_pkg::REG_ENC_RGB) begin
          exp_data = {13'h0000, rgb_val};
        end
      end
      4'd2: begin
        if (idx == soc_pkg::REG_HEX_VALUE) begin
          exp_data = hex_val;
        end
      end
      4'd3: exp_data = {8'h00, sw};
      default: exp_data = '0;
    endcase
  end

  always @(negedge clock_50) begin
    if (!rst) begin
      if (psel && penable && (!pwrite || unmapped)) begin
        reads++;
        if (((prdata ^ exp_data) & exp_mask) !== 16'h0000) begin
          report_mismatch("prdata", exp_data, prdata);
        end
      end
      if (pslverr !== (psel && penable && unmapped)) begin
        report_mismatch("pslverr", 16'(psel && penable && unmapped), 16'(pslverr));
      end
      if (rgb !== rgb_val) begin
        report_mismatch("rgb", 16'(rgb_val), 16'(rgb));
      end
      if (hex0 !== seg_font(seg_val[3:0])) begin
        report_mismatch("hex0", 16'(seg_font(seg_val[3:0])), 16'(hex0));
      end
      if (hex1 !== seg_font(seg_val[7:4])) begin
        report_mismatch("hex1", 16'(seg_font(seg_val[7:4])), 16'(hex1));
      end
      if (hex2 !== seg_font(seg_val[11:8])) begin
        report_mismatch("hex2", 16'(seg_font(seg_val[11:8])), 16'(hex2));
      end
      if (hex3 !== seg_font(seg_val[15:12])) begin
        report_mismatch("hex3", 16'(seg_font(seg_val[15:12])), 16'(hex3));
      end
    end
  end

endmodule

// File: sim/tb_soc_periph.sv
`timescale 1ns/100ps

module tb_soc_periph;

  localparam int CLK_PERIOD = 8;
  localparam int DRIVE_DELAY = 1;
  localparam int WATCHDOG_CYCLES = 2 * (30 * 10 * soc_pkg::UART_DIV + 200 * 6 + 200);
  localparam int POLL_LIMIT = 20 * soc_pkg::UART_DIV;

  logic clock_50;
  logic rst;
  logic psel;
  logic penable;
  logic pwrite;
  logic [soc_pkg::ADDR_W-1:0] paddr;
  logic [soc_pkg::DATA_W-1:0] pwdata;
  logic [soc_pkg::DATA_W-1:0] prdata;
  logic pslverr;
  logic [7:0] sw;
  logic [1:0] quad;
  logic button;
  logic [2:0] rgb;
  logic serial_loop;
  soc_pkg::seg7_t hex0;
  soc_pkg::seg7_t hex1;
  soc_pkg::seg7_t hex2;
  soc_pkg::seg7_t hex3;

  int seed = 70781;
  int tb_errors = 0;
  int test_num = 0;
  int passed = 0;
  int err_mark = 0;
  int quad_pos = 0;
  logic [31:0] rnd;
  logic [15:0] rd;

  soc_periph DUT (
    .clock_50(clock_50), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pslverr(pslverr), .sw(sw), .quad(quad), .button(button),
    .rgb(rgb), .serial_tx(serial_loop), .serial_rx(serial_loop),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3)
  );

  soc_checker u_check (
    .clock_50(clock_50), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pslverr(pslverr), .sw(sw), .quad(quad), .button(button),
    .rgb(rgb), .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3)
  );

  initial begin
    clock_50 = 1'b0;
    forever #(CLK_PERIOD / 2) clock_50 = ~clock_50;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock_50);
    $display("Watchdog expired after %0d cycles, test sequence did not finish",
             WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [11:0] reg_addr(input logic [3:0] region, input logic [1:0] idx);
    return {region, 4'h0, idx, 2'b00};
  endfunction

  function automatic logic [1:0] gray_of(input int pos);
    case (pos)
      0: gray_of = 2'b00;
      1: gray_of = 2'b01;
      2: gray_of = 2'b11;
      default: gray_of = 2'b10;
    endcase
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clock_50);
    #DRIVE_DELAY;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [15:0] data);
    @(posedge clock_50);
    #DRIVE_DELAY;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clock_50);
    #DRIVE_DELAY;
    penable = 1'b1;
    @(posedge clock_50);
    #DRIVE_DELAY;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [15:0] data);
    @(posedge clock_50);
    #DRIVE_DELAY;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge clock_50);
    #DRIVE_DELAY;
    penable = 1'b1;
    @(negedge clock_50);
    data = prdata;
    @(posedge clock_50);
    #DRIVE_DELAY;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic poll_uart_stat(input int bit_idx, input logic level);
    logic [15:0] stat;
    int polls;
    polls = 0;
    apb_read(reg_addr(soc_pkg::PER_UART, soc_pkg::REG_UART_STAT), stat);
    while (stat[bit_idx] !== level && polls < POLL_LIMIT) begin
      polls++;
      apb_read(reg_addr(soc_pkg::PER_UART, soc_pkg::REG_UART_STAT), stat);
    end
    if (stat[bit_idx] !== level) begin
      $display("UART status bit %0d never reached %b within %0d polls",
               bit_idx, level, polls);
      tb_errors++;
    end
  endtask

  // Holds each pin state for 5 cycles
  task automatic step_encoder(input int dir);
    quad_pos = (quad_pos + dir + 4) % 4;
    @(posedge clock_50);
    #DRIVE_DELAY;
    quad = gray_of(quad_pos);
    wait_cycles(4);
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = u_check.errors + tb_errors - err_mark;
    err_mark = u_check.errors + tb_errors;
    test_num++;
    if (errs == 0) begin
      passed++;
    end
    $display("Test %0d %s: %s (%0d errors)", test_num, name, errs == 0 ? "pass" : "FAIL", errs);
  endtask

  initial begin
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    sw = 8'h00;
    quad = 2'b00;
    button = 1'b0;
    wait_cycles(8);
    rst = 1'b0;

    apb_read(reg_addr(soc_pkg::PER_UART, soc_pkg::REG_UART_DATA), rd);
    apb_read(reg_addr(soc_pkg::PER_UART, soc_pkg::REG_UART_STAT), rd);
    apb_read(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_COUNT), rd);
    apb_read(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_STAT), rd);
    apb_read(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_RGB), rd);
    apb_read(reg_addr(soc_pkg::PER_HEX, soc_pkg::REG_HEX_VALUE), rd);
    apb_read(reg_addr(soc_pkg::PER_SW, 2'd0), rd);
    finish_test("reset values");

    repeat (20) begin
      rnd = $random(seed);
      apb_write(reg_addr(soc_pkg::PER_HEX, soc_pkg::REG_HEX_VALUE), rnd[15:0]);
      wait_cycles(2);
      apb_read(reg_addr(soc_pkg::PER_HEX, soc_pkg::REG_HEX_VALUE), rd);
    end
    finish_test("hex display");

    repeat (10) begin
      poll_uart_stat(0, 1'b0);
      rnd = $random(seed);
      apb_write(reg_addr(soc_pkg::PER_UART, soc_pkg::REG_UART_DATA), {8'h00, rnd[7:0]});
      poll_uart_stat(1, 1'b1);
      apb_read(reg_addr(soc_pkg::PER_UART, soc_pkg::REG_UART_DATA), rd);
      apb_read(reg_addr(soc_pkg::PER_UART, soc_pkg::REG_UART_STAT), rd);
    end
    finish_test("uart loopback");

    rnd = $random(seed);
    apb_write(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_COUNT), rnd[15:0]);
    apb_read(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_COUNT), rd);
    for (int i = 1; i <= 160; i++) begin
      rnd = $random(seed);
      step_encoder(rnd[0] ? 1 : -1);
      if (i % 4 == 0) begin
        apb_read(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_COUNT), rd);
      end
    end
    button = 1'b1;
    wait_cycles(5);
    button = 1'b0;
    wait_cycles(5);
    apb_read(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_STAT), rd);
    apb_write(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_STAT), 16'h0000);
    apb_read(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_STAT), rd);
    finish_test("encoder walk and button");

    repeat (10) begin
      rnd = $random(seed);
      apb_write(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_RGB), rnd[15:0]);
      apb_read(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_RGB), rd);
      sw = rnd[23:16];
      apb_read(reg_addr(soc_pkg::PER_SW, rnd[25:24]), rd);
    end
    finish_test("rgb and switches");

    for (int r = 4; r < 16; r++) begin
      rnd = $random(seed);
      apb_write({4'(r), rnd[7:0]}, rnd[31:16]);
      apb_read({4'(r), rnd[15:8]}, rd);
    end
    apb_read(reg_addr(soc_pkg::PER_HEX, soc_pkg::REG_HEX_VALUE), rd);
    apb_read(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_COUNT), rd);
    apb_read(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_STAT), rd);
    apb_read(reg_addr(soc_pkg::PER_ENC, soc_pkg::REG_ENC_RGB), rd);
    apb_read(reg_addr(soc_pkg::PER_UART, soc_pkg::REG_UART_DATA), rd);
    finish_test("unmapped regions");

    $display("Tests %0d, passed %0d, failed %0d, reads checked %0d, errors %0d",
             test_num, passed, test_num - passed, u_check.reads,
             u_check.errors + tb_errors);
    if (u_check.errors + tb_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
design/soc_pkg.sv
design/periph_decode.sv
design/uart.sv
design/quad_encoder.sv
design/hex_display.sv
design/soc_periph.sv
sim/soc_checker.sv
sim/tb_soc_periph.sv
